// File: all.f
design/set_ops_pkg.sv
design/config_axil_write_port.sv
design/set_ops_configure_memory.sv
design/config_axil_read_port.sv
design/set_ops_config_top.sv
tb/set_ops_config_checker.sv
tb/tb_set_ops_config.sv

// File: design/config_axil_read_port.sv
`timescale 1ns/100ps
`default_nettype none

module config_axil_read_port
    import set_ops_pkg::*;
(
    input  logic             ap_clk,
    input  logic             areset_fifo,
    input  axil_rd_req_t     rd_req,
    output axil_rd_rsp_t     rd_rsp,
    input  set_ops_config_t  lane_heads [NUM_LANES],
    input  lane_fifo_state_t lane_states [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_pop
);

    read_state_t          read_state;
    logic                 read_accept;
    logic [NUM_LANES-1:0] lane_nonempty;
    logic [NUM_LANES-1:0] lane_overflow;
    logic                 pick_found;
    type_lane_id          pick_lane;
    set_ops_config_t      pick_head;
    type_axil_data        read_word;
    type_axil_data        read_data;

    assign read_accept = (read_state == RD_IDLE) && rd_req.arvalid;

    // --------------------
    // lane selection
    // --------------------
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_nonempty[l] = !lane_states[l].empty;
            lane_overflow[l] = lane_states[l].overflow;
        end
    end

    // walk downward so the lowest lane wins
    always_comb begin
        pick_found = 1'b0;
        pick_lane  = '0;
        for (int l = NUM_LANES - 1; l >= 0; l--) begin
            if (lane_nonempty[l]) begin
                pick_found = 1'b1;
                pick_lane  = type_lane_id'(l);
            end
        end
    end

    assign pick_head = lane_heads[pick_lane];

    always_comb begin
        lane_pop = '0;
        if (read_accept && (rd_req.araddr == POP_ADDR) && pick_found) begin
            lane_pop[pick_lane] = 1'b1;
        end
    end

    // --------------------
    // address decode
    // --------------------
    always_comb begin
        read_word = '0;
        if (rd_req.araddr == POP_ADDR) begin
            if (pick_found) begin
                read_word[POP_VALID_BIT] = 1'b1;
                read_word[POP_LANE_LSB +: $bits(type_lane_id)] = pick_lane;
                read_word[POP_OP_LSB +: $bits(type_set_op)]    = pick_head.set_op;
                read_word[POP_MASK_LSB +: $bits(type_set_mask)] = pick_head.set_mask;
            end
        end else if (rd_req.araddr == STATUS_ADDR) begin
            read_word[STATUS_NONEMPTY_LSB +: NUM_LANES] = lane_nonempty;
            read_word[STATUS_OVERFLOW_LSB +: NUM_LANES] = lane_overflow;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (read_accept) begin
            read_data <= read_word;
        end
    end

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            read_state <= RD_RESET;
        end else begin
            case (read_state)
                RD_RESET: begin
                    read_state <= RD_IDLE;
                end
                RD_IDLE: begin
                    if (read_accept) begin
                        read_state <= RD_RESP;
                    end
                end
                RD_RESP: begin
                    if (rd_req.rready) begin
                        read_state <= RD_IDLE;
                    end
                end
                default: begin
                    read_state <= RD_IDLE;
                end
            endcase
        end
    end

    assign rd_rsp.arready = (read_state == RD_IDLE);
    assign rd_rsp.rvalid  = (read_state == RD_RESP);
    assign rd_rsp.rdata   = read_data;
    assign rd_rsp.rresp   = RESP_OKAY;

endmodule

`default_nettype wire

// File: design/config_axil_write_port.sv
`timescale 1ns/100ps
`default_nettype none

module config_axil_write_port
    import set_ops_pkg::*;
(
    input  logic             ap_clk,
    input  logic             areset_fifo,
    input  axil_wr_req_t     wr_req,
    output axil_wr_rsp_t     wr_rsp,
    output memory_response_t response_packet
);

    write_state_t  write_state;
    logic          write_accept;
    logic          packet_valid;
    type_offset    packet_offset;
    type_axil_data packet_data;

    // address and data must arrive together
    assign write_accept = (write_state == WR_IDLE) && wr_req.awvalid && wr_req.wvalid;

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            write_state  <= WR_RESET;
            packet_valid <= 1'b0;
        end else begin
            packet_valid <= 1'b0;
            case (write_state)
                WR_RESET: begin
                    write_state <= WR_IDLE;
                end
                WR_IDLE: begin
                    if (write_accept) begin
                        write_state  <= WR_RESP;
                        packet_valid <= 1'b1;
                    end
                end
                WR_RESP: begin
                    // hold B until the manager takes it
                    if (wr_req.bready) begin
                        write_state <= WR_IDLE;
                    end
                end
                default: begin
                    write_state <= WR_IDLE;
                end
            endcase
        end
    end

    // byte address to word offset
    always_ff @(posedge ap_clk) begin
        if (write_accept) begin
            packet_offset <= type_offset'(wr_req.awaddr >> 2);
            packet_data   <= wr_req.wdata;
        end
    end

    // --------------------
    // outputs
    // --------------------
    assign wr_rsp.awready = write_accept;
    assign wr_rsp.wready  = write_accept;
    assign wr_rsp.bvalid  = (write_state == WR_RESP);
    assign wr_rsp.bresp   = RESP_OKAY;

    // broadcast to every lane
    assign response_packet.valid  = packet_valid;
    assign response_packet.offset = packet_offset;
    assign response_packet.data   = packet_data;

endmodule

`default_nettype wire

// File: design/set_ops_config_top.sv
`timescale 1ns/100ps
`default_nettype none

module set_ops_config_top
    import set_ops_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_fifo,
    input  axil_wr_req_t wr_req,
    output axil_wr_rsp_t wr_rsp,
    input  axil_rd_req_t rd_req,
    output axil_rd_rsp_t rd_rsp
);

    memory_response_t     response_packet;
    set_ops_config_t      lane_heads [NUM_LANES];
    lane_fifo_state_t     lane_states [NUM_LANES];
    logic [NUM_LANES-1:0] lane_pop;

    // --------------------
    // register writes
    // --------------------
    config_axil_write_port config_axil_write_port_i (
        .ap_clk          (ap_clk),
        .areset_fifo     (areset_fifo),
        .wr_req          (wr_req),
        .wr_rsp          (wr_rsp),
        .response_packet (response_packet)
    );

    // one lane per window, all see the same packet
    for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
        set_ops_configure_memory #(
            .LANE_INDEX (l)
        ) set_ops_configure_memory_i (
            .ap_clk          (ap_clk),
            .areset_fifo     (areset_fifo),
            .response_packet (response_packet),
            .pop             (lane_pop[l]),
            .config_head     (lane_heads[l]),
            .fifo_state      (lane_states[l])
        );
    end

    // --------------------
    // readback
    // --------------------
    config_axil_read_port config_axil_read_port_i (
        .ap_clk      (ap_clk),
        .areset_fifo (areset_fifo),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp),
        .lane_heads  (lane_heads),
        .lane_states (lane_states),
        .lane_pop    (lane_pop)
    );

endmodule

`default_nettype wire

// File: design/set_ops_configure_memory.sv
`timescale 1ns/100ps
`default_nettype none

module set_ops_configure_memory
    import set_ops_pkg::*;
#(
    parameter int LANE_INDEX = 0
) (
    input  logic             ap_clk,
    input  logic             areset_fifo,
    input  memory_response_t response_packet,
    input  logic             pop,
    output set_ops_config_t  config_head,
    output lane_fifo_state_t fifo_state
);

    memory_response_t              in_reg;
    type_offset                    in_rel;
    logic                          in_keep;
    logic [ENGINE_SEQ_WIDTH-1:0]   seq_next_word;
    set_ops_config_t               cfg_reg;
    logic                          push_valid;
    set_ops_config_t               fifo_mem [LANE_FIFO_DEPTH];
    type_lane_ptr                  wr_ptr;
    type_lane_ptr                  rd_ptr;
    logic                          fifo_empty;
    logic                          fifo_full;
    logic                          overflow;

    // --------------------
    // input register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            in_reg.valid <= 1'b0;
        end else begin
            in_reg.valid <= response_packet.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        in_reg.offset <= response_packet.offset;
        in_reg.data   <= response_packet.data;
    end

    // window filter, offsets below base wrap to large values
    assign in_rel  = in_reg.offset - lane_window_base(LANE_INDEX);
    assign in_keep = in_reg.valid && (in_rel < type_offset'(ENGINE_SEQ_WIDTH));

    // --------------------
    // sequence tracker
    // --------------------
    // bit 0 set means idle, waiting for the mask word at base
    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            seq_next_word <= ENGINE_SEQ_WIDTH'(1);
            push_valid    <= 1'b0;
        end else begin
            push_valid <= 1'b0;
            if (in_keep) begin
                if (seq_next_word[0]) begin
                    if (in_rel == '0) begin
                        seq_next_word <= seq_next_word << 1;
                    end
                end else if (seq_next_word[ENGINE_SEQ_WIDTH-1]) begin
                    seq_next_word <= ENGINE_SEQ_WIDTH'(1);
                    push_valid    <= 1'b1;
                end else begin
                    seq_next_word <= seq_next_word << 1;
                end
            end
        end
    end

    // capture fields as the words arrive
    always_ff @(posedge ap_clk) begin
        if (in_keep) begin
            if (seq_next_word[0] && (in_rel == '0)) begin
                cfg_reg.set_mask <= in_reg.data[$bits(type_set_mask)-1:0];
            end
            if (seq_next_word[ENGINE_SEQ_WIDTH-1]) begin
                cfg_reg.set_op <= in_reg.data[$bits(type_set_op)-1:0];
            end
        end
    end

    // --------------------
    // lane fifo
    // --------------------
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[LANE_PTR_WIDTH] != rd_ptr[LANE_PTR_WIDTH]) &&
                        (wr_ptr[LANE_PTR_WIDTH-1:0] == rd_ptr[LANE_PTR_WIDTH-1:0]);

    always_ff @(posedge ap_clk) begin
        if (areset_fifo) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_valid) begin
                if (fifo_full) begin
                    overflow <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop && !fifo_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push_valid && !fifo_full) begin
            fifo_mem[wr_ptr[LANE_PTR_WIDTH-1:0]] <= cfg_reg;
        end
    end

    assign config_head         = fifo_mem[rd_ptr[LANE_PTR_WIDTH-1:0]];
    assign fifo_state.empty    = fifo_empty;
    assign fifo_state.full     = fifo_full;
    assign fifo_state.overflow = overflow;

endmodule

`default_nettype wire

// File: design/set_ops_pkg.sv
`default_nettype none

package set_ops_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int NUM_LANES        = 4;
    localparam int ENGINE_SEQ_WIDTH = 2;
    localparam int LANE_FIFO_DEPTH  = 4;
    localparam int LANE_PTR_WIDTH   = $clog2(LANE_FIFO_DEPTH);
    localparam int AXIL_ADDR_WIDTH  = 12;
    localparam int AXIL_DATA_WIDTH  = 32;
    localparam int AXIL_STRB_WIDTH  = AXIL_DATA_WIDTH / 8;

    typedef logic [7:0]                 type_offset;
    typedef logic [7:0]                 type_set_mask;
    typedef logic [2:0]                 type_set_op;
    typedef logic [1:0]                 type_lane_id;
    typedef logic [LANE_PTR_WIDTH:0]    type_lane_ptr;
    typedef logic [AXIL_ADDR_WIDTH-1:0] type_axil_addr;
    typedef logic [AXIL_DATA_WIDTH-1:0] type_axil_data;
    typedef logic [AXIL_STRB_WIDTH-1:0] type_axil_strb;
    typedef logic [1:0]                 type_axil_resp;

    // --------------------
    // register map
    // --------------------
    localparam type_axil_addr POP_ADDR    = 12'h040;
    localparam type_axil_addr STATUS_ADDR = 12'h044;
    localparam type_axil_resp RESP_OKAY   = 2'b00;

    // pop word fields
    localparam int POP_VALID_BIT = 31;
    localparam int POP_LANE_LSB  = 16;
    localparam int POP_OP_LSB    = 8;
    localparam int POP_MASK_LSB  = 0;

    // status word fields
    localparam int STATUS_NONEMPTY_LSB = 0;
    localparam int STATUS_OVERFLOW_LSB = 8;

    typedef struct packed {
        logic          valid;
        type_offset    offset;
        type_axil_data data;
    } memory_response_t;

    typedef struct packed {
        type_set_mask set_mask;
        type_set_op   set_op;
    } set_ops_config_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic overflow;
    } lane_fifo_state_t;

    typedef struct packed {
        logic          awvalid;
        type_axil_addr awaddr;
        logic          wvalid;
        type_axil_data wdata;
        type_axil_strb wstrb;
        logic          bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic          awready;
        logic          wready;
        logic          bvalid;
        type_axil_resp bresp;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic          arvalid;
        type_axil_addr araddr;
        logic          rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic          arready;
        logic          rvalid;
        type_axil_data rdata;
        type_axil_resp rresp;
    } axil_rd_rsp_t;

    typedef enum logic [1:0] {
        WR_RESET,
        WR_IDLE,
        WR_RESP
    } write_state_t;

    typedef enum logic [1:0] {
        RD_RESET,
        RD_IDLE,
        RD_RESP
    } read_state_t;

    // first offset of a lane window
    function automatic type_offset lane_window_base(int lane);
        return type_offset'(lane * ENGINE_SEQ_WIDTH);
    endfunction

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_set_ops_config \
    -f all.f \
    -o sim_set_ops_config

sim_output=$(./obj_dir/sim_set_ops_config)
echo "$sim_output"

if echo "$sim_output" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi

// File: tb/set_ops_config_checker.sv
`timescale 1ns/100ps
`default_nettype none

module set_ops_config_checker
    import set_ops_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_fifo,
    input  axil_wr_req_t wr_req,
    input  axil_wr_rsp_t wr_rsp,
    input  axil_rd_req_t rd_req,
    input  axil_rd_rsp_t rd_rsp,
    output int           error_count,
    output int           write_count,
    output int           read_count
);

    int              errors = 0;
    int              writes = 0;
    int              reads = 0;
    int              writes_pending = 0;
    logic            reset_prev = 1'b0;
    type_axil_data   expected_rdata [$];

    // reference model of the lanes
    set_ops_config_t model_fifo [NUM_LANES][LANE_FIFO_DEPTH];
    int              model_count [NUM_LANES];
    logic            model_armed [NUM_LANES];
    type_set_mask    model_mask [NUM_LANES];
    logic            model_overflow [NUM_LANES];

    assign error_count = errors;
    assign write_count = writes;
    assign read_count  = reads;

    task automatic report_mismatch(input string name, input type_axil_data expected,
                                   input type_axil_data actual);
        $display("error: time %0t ns signal %s expected 0x%08h actual 0x%08h",
                 $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string text);
        $display("failure at time %0t ns: %s", $time, text);
        errors++;
    endtask

    task automatic reset_model();
        for (int l = 0; l < NUM_LANES; l++) begin
            model_count[l]    = 0;
            model_armed[l]    = 1'b0;
            model_mask[l]     = '0;
            model_overflow[l] = 1'b0;
        end
        expected_rdata.delete();
        writes_pending = 0;
    endtask

    // --------------------
    // lane rule
    // --------------------
    task automatic model_write(input type_axil_addr addr, input type_axil_data data);
        int offset;
        int lane;
        int rel;
        offset = int'(addr[9:2]);
        lane   = offset / ENGINE_SEQ_WIDTH;
        rel    = offset % ENGINE_SEQ_WIDTH;
        if (lane < NUM_LANES) begin
            if (!model_armed[lane]) begin
                // only the base word starts a record
                if (rel == 0) begin
                    model_mask[lane]  = data[7:0];
                    model_armed[lane] = 1'b1;
                end
            end else begin
                model_armed[lane] = 1'b0;
                if (model_count[lane] == LANE_FIFO_DEPTH) begin
                    model_overflow[lane] = 1'b1;
                end else begin
                    model_fifo[lane][model_count[lane]].set_mask = model_mask[lane];
                    model_fifo[lane][model_count[lane]].set_op   = data[2:0];
                    model_count[lane]++;
                end
            end
        end
    endtask

    task automatic model_read(input type_axil_addr addr, output type_axil_data word);
        int pick;
        word = '0;
        pick = -1;
        for (int l = NUM_LANES - 1; l >= 0; l--) begin
            if (model_count[l] != 0) begin
                pick = l;
            end
        end
        if (addr == 12'h040) begin
            if (pick >= 0) begin
                word[31]    = 1'b1;
                word[17:16] = 2'(pick);
                word[10:8]  = model_fifo[pick][0].set_op;
                word[7:0]   = model_fifo[pick][0].set_mask;
                for (int i = 1; i < LANE_FIFO_DEPTH; i++) begin
                    model_fifo[pick][i-1] = model_fifo[pick][i];
                end
                model_count[pick]--;
            end
        end else if (addr == 12'h044) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                word[l]     = (model_count[l] != 0);
                word[8 + l] = model_overflow[l];
            end
        end
    endtask

    // --------------------
    // port monitor
    // --------------------
    // sampled mid-cycle where every port is stable
    always @(negedge ap_clk) begin
        type_axil_data expected_word;
        if (reset_prev && (wr_rsp.awready || wr_rsp.wready || wr_rsp.bvalid ||
                           rd_rsp.arready || rd_rsp.rvalid)) begin
            report_failure("handshake output active during or just after reset");
        end
        if (areset_fifo) begin
            reset_model();
            reset_prev = 1'b1;
        end else begin
            reset_prev = 1'b0;
            if (wr_rsp.awready !== wr_rsp.wready) begin
                report_failure("write address ready and write data ready differ");
            end
            if (wr_rsp.bvalid && (writes_pending == 0)) begin
                report_failure("write response with no write outstanding");
            end
            if (wr_req.awvalid && wr_rsp.awready) begin
                model_write(wr_req.awaddr, wr_req.wdata);
                writes++;
                writes_pending++;
            end
            if (wr_rsp.bvalid && wr_req.bready) begin
                if (wr_rsp.bresp !== 2'b00) begin
                    report_mismatch("wr_rsp.bresp", 32'h0, 32'(wr_rsp.bresp));
                end
                if (writes_pending > 0) begin
                    writes_pending--;
                end
            end
            if (rd_rsp.rvalid && (expected_rdata.size() == 0)) begin
                report_failure("read response with no read outstanding");
            end
            if (rd_req.arvalid && rd_rsp.arready) begin
                model_read(rd_req.araddr, expected_word);
                expected_rdata.push_back(expected_word);
                reads++;
            end
            if (rd_rsp.rvalid && rd_req.rready) begin
                if (expected_rdata.size() != 0) begin
                    expected_word = expected_rdata.pop_front();
                    if (rd_rsp.rdata !== expected_word) begin
                        report_mismatch("rd_rsp.rdata", expected_word, rd_rsp.rdata);
                    end
                end
                if (rd_rsp.rresp !== 2'b00) begin
                    report_mismatch("rd_rsp.rresp", 32'h0, 32'(rd_rsp.rresp));
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_set_ops_config.sv
`timescale 1ns/100ps
`default_nettype none

module tb_set_ops_config
    import set_ops_pkg::*;
;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int IDLE_CYCLES    = 10;
    localparam int RANDOM_ROUNDS  = 4;
    localparam int RANDOM_WRITES  = 24;
    localparam int POPS_PER_ROUND = NUM_LANES * LANE_FIFO_DEPTH + 1;
    localparam int DIRECTED_OPS   = 31;
    localparam int TOTAL_OPS      = DIRECTED_OPS +
                                    RANDOM_ROUNDS * (RANDOM_WRITES + 1 + POPS_PER_ROUND);
    localparam int WATCHDOG_NS    = TOTAL_OPS * 20 * CLK_PERIOD;
    localparam int SEED           = 32'h23375627;

    logic         ap_clk;
    logic         areset_fifo;
    axil_wr_req_t wr_req;
    axil_wr_rsp_t wr_rsp;
    axil_rd_req_t rd_req;
    axil_rd_rsp_t rd_rsp;
    int           error_count;
    int           write_count;
    int           read_count;

    set_ops_config_top set_ops_config_top_i (
        .ap_clk      (ap_clk),
        .areset_fifo (areset_fifo),
        .wr_req      (wr_req),
        .wr_rsp      (wr_rsp),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp)
    );

    set_ops_config_checker set_ops_config_checker_i (
        .ap_clk      (ap_clk),
        .areset_fifo (areset_fifo),
        .wr_req      (wr_req),
        .wr_rsp      (wr_rsp),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp),
        .error_count (error_count),
        .write_count (write_count),
        .read_count  (read_count)
    );

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    // --------------------
    // bus tasks
    // --------------------
    // all tasks start and end 2 ns after a rising edge
    task automatic hold_ready_low();
        int delay;
        delay = $urandom_range(3, 0);
        repeat (delay) begin
            @(posedge ap_clk);
            #2;
        end
    endtask

    task automatic write_word(input logic [7:0] offset, input type_axil_data data);
        logic taken;
        wr_req.awvalid = 1'b1;
        wr_req.awaddr  = type_axil_addr'({offset, 2'b00});
        wr_req.wvalid  = 1'b1;
        wr_req.wdata   = data;
        wr_req.wstrb   = type_axil_strb'($urandom);
        taken = 1'b0;
        while (!taken) begin
            @(negedge ap_clk);
            taken = wr_rsp.awready;
            @(posedge ap_clk);
        end
        #2;
        wr_req.awvalid = 1'b0;
        wr_req.wvalid  = 1'b0;
        hold_ready_low();
        wr_req.bready = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge ap_clk);
            taken = wr_rsp.bvalid;
            @(posedge ap_clk);
        end
        #2;
        wr_req.bready = 1'b0;
    endtask

    task automatic read_reg(input type_axil_addr addr);
        logic taken;
        rd_req.arvalid = 1'b1;
        rd_req.araddr  = addr;
        taken = 1'b0;
        while (!taken) begin
            @(negedge ap_clk);
            taken = rd_rsp.arready;
            @(posedge ap_clk);
        end
        #2;
        rd_req.arvalid = 1'b0;
        hold_ready_low();
        rd_req.rready = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge ap_clk);
            taken = rd_rsp.rvalid;
            @(posedge ap_clk);
        end
        #2;
        rd_req.rready = 1'b0;
    endtask

    // lets every packet in flight reach its lane FIFO
    task automatic wait_idle();
        repeat (IDLE_CYCLES) @(posedge ap_clk);
        #2;
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin
        void'($urandom(SEED));
        wr_req      = '0;
        rd_req      = '0;
        areset_fifo = 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        #2;
        areset_fifo = 1'b0;

        // empty after reset
        read_reg(12'h044);
        read_reg(12'h040);

        // out of window, idle non-base, two good records
        write_word(8'd9, $urandom);
        write_word(8'd1, $urandom);
        write_word(8'd4, $urandom);
        write_word(8'd5, $urandom);
        write_word(8'd0, $urandom);
        write_word(8'd0, $urandom);
        write_word(8'd11, $urandom);
        wait_idle();
        repeat (3) read_reg(12'h040);

        // six records into lane 1 overflow a depth-4 FIFO
        for (int r = 0; r < 6; r++) begin
            write_word(8'd2, $urandom);
            write_word(8'd3, $urandom);
        end
        wait_idle();
        read_reg(12'h044);
        repeat (5) read_reg(12'h040);
        read_reg(12'h044);

        for (int round = 0; round < RANDOM_ROUNDS; round++) begin
            for (int i = 0; i < RANDOM_WRITES; i++) begin
                write_word(8'($urandom_range(11, 0)), $urandom);
            end
            wait_idle();
            read_reg(12'h044);
            repeat (POPS_PER_ROUND) read_reg(12'h040);
        end

        $display("errors %0d, writes %0d, reads %0d", error_count, write_count, read_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
